// File: io_combiner.sv
`timescale 1ns/10ps

module io_combiner #(
    parameter int NUM_DEVICES = io_pkg::DEF_NUM_DEVICES
) (
    input                           clk,
    input                           rst_n,
    input                           stage_valid,
    input                           stage_write,
    input  io_pkg::data_t           dev_rdata [NUM_DEVICES],
    input        [NUM_DEVICES-1:0]  dev_irq,
    output                          advance,        // Staged item moves to the response
    output                          stall,
    output logic                    resp_valid,
    input                           resp_ready,
    output io_pkg::data_t           resp_data,
    output                          interrupt
);

    io_pkg::data_t merged;

    // Wired-AND of the device buses, idle devices drive all ones
    always_comb begin
        merged = io_pkg::DATA_IDLE;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            merged = merged & dev_rdata[i];
        end
        if (stage_write) begin
            merged = io_pkg::DATA_IDLE;             // Writes answer with idle
        end
    end

    // Held response blocks the whole pipe
    assign stall   = resp_valid & ~resp_ready;
    assign advance = stage_valid & ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (!stall) begin
            resp_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resp_data <= merged;
        end
    end

    // Wired-OR of the interrupt lines
    assign interrupt = |dev_irq;

endmodule

// File: io_decoder.sv
`timescale 1ns/10ps

module io_decoder #(
    parameter int            NUM_DEVICES = io_pkg::DEF_NUM_DEVICES,
    parameter io_pkg::port_t BASE_PORT   = io_pkg::DEF_BASE_PORT
) (
    input                           clk,
    input                           rst_n,
    input                           req_valid,
    input  io_pkg::port_t           req_port,
    input                           req_write,
    input  io_pkg::data_t           req_wdata,
    output                          req_ready,
    input                           stall,          // Response register is full
    output logic                    stage_valid,
    output logic [NUM_DEVICES-1:0]  dev_sel,        // One-hot, zero when unmapped
    output io_pkg::reg_idx_t        dev_reg,
    output logic                    dev_write,
    output io_pkg::data_t           dev_wdata
);

    io_pkg::port_t          offset;
    logic [5:0]             win_idx;
    logic                   mapped;
    logic [NUM_DEVICES-1:0] sel_next;
    logic [NUM_DEVICES-1:0] stage_sel;

    // Position of the port relative to the first window
    assign offset  = req_port - BASE_PORT;
    assign win_idx = offset[7:2];                   // Four ports per window
    assign mapped  = (req_port >= BASE_PORT) && (win_idx < NUM_DEVICES);

    always_comb begin
        sel_next = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            if (mapped && win_idx == 6'(i)) begin
                sel_next[i] = 1'b1;
            end
        end
    end

    // A new request can enter whenever the stage is free to move
    assign req_ready = ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (!stall) begin
            stage_valid <= req_valid;               // Bubble when nothing offered
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_sel <= sel_next;
            dev_reg   <= req_port[1:0];
            dev_write <= req_write;
            dev_wdata <= req_wdata;
        end
    end

    // Only a live item may strobe a device
    assign dev_sel = stage_valid ? stage_sel : '0;

endmodule

// File: io_devices.sv
`timescale 1ns/10ps

module io_devices #(
    parameter int            NUM_DEVICES = io_pkg::DEF_NUM_DEVICES,
    parameter io_pkg::port_t BASE_PORT   = io_pkg::DEF_BASE_PORT
) (
    input                   clk,
    input                   rst_n,
    input                   req_valid,                  // CPU request side
    output                  req_ready,
    input  io_pkg::port_t   req_port,
    input                   req_write,
    input  io_pkg::data_t   req_wdata,
    output                  resp_valid,                 // Response side
    input                   resp_ready,
    output io_pkg::data_t   resp_data,
    output                  interrupt                   // Level, OR of all devices
);

    wire                    stall;
    wire                    advance;
    wire                    stage_valid;
    wire [NUM_DEVICES-1:0]  dev_sel;
    io_pkg::reg_idx_t       dev_reg;
    wire                    dev_write;
    io_pkg::data_t          dev_wdata;
    io_pkg::data_t          dev_rdata [NUM_DEVICES];
    wire [NUM_DEVICES-1:0]  dev_irq;

    io_decoder #(
        .NUM_DEVICES (NUM_DEVICES),
        .BASE_PORT   (BASE_PORT)
    ) io_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_port    (req_port),
        .req_write   (req_write),
        .req_wdata   (req_wdata),
        .req_ready   (req_ready),
        .stall       (stall),
        .stage_valid (stage_valid),
        .dev_sel     (dev_sel),
        .dev_reg     (dev_reg),
        .dev_write   (dev_write),
        .dev_wdata   (dev_wdata)
    );

    // One window of four ports per device
    for (genvar i = 0; i < NUM_DEVICES; i++) begin : g_dev
        io_reg_device io_reg_device (
            .clk     (clk),
            .rst_n   (rst_n),
            .sel     (dev_sel[i]),
            .reg_idx (dev_reg),
            .write   (dev_write),
            .wdata   (dev_wdata),
            .advance (advance),
            .rdata   (dev_rdata[i]),
            .irq     (dev_irq[i])
        );
    end

    io_combiner #(
        .NUM_DEVICES (NUM_DEVICES)
    ) io_combiner (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .stage_write (dev_write),
        .dev_rdata   (dev_rdata),
        .dev_irq     (dev_irq),
        .advance     (advance),
        .stall       (stall),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .interrupt   (interrupt)
    );

endmodule

// File: io_pkg.sv
package io_pkg;

    // Bus widths
    typedef logic [7:0] port_t;                         // I/O port address
    typedef logic [7:0] data_t;                         // I/O data byte
    typedef logic [1:0] reg_idx_t;                      // Register inside a device window

    // Value a non-selected device drives, so the AND merge passes the others through
    localparam data_t DATA_IDLE = 8'hFF;

    // Register 3 of each window is status, the rest are plain storage
    localparam reg_idx_t STATUS_REG = 2'd3;

    // Defaults for the top level parameters
    localparam int    DEF_NUM_DEVICES = 4;              // Up to 16 windows
    localparam port_t DEF_BASE_PORT   = 8'h40;          // Multiple of 4

endpackage

// File: io_reg_device.sv
`timescale 1ns/10ps

module io_reg_device (
    input                       clk,
    input                       rst_n,
    input                       sel,            // Window hit for the staged access
    input  io_pkg::reg_idx_t    reg_idx,
    input                       write,
    input  io_pkg::data_t       wdata,
    input                       advance,        // Stage moves on this edge
    output io_pkg::data_t       rdata,
    output                      irq
);

    io_pkg::data_t  regs [0:2];                     // Plain storage registers
    logic           pending;
    logic           strobe;
    logic           is_status;

    assign strobe    = sel & advance;
    assign is_status = (reg_idx == io_pkg::STATUS_REG);

    always_ff @(posedge clk) begin
        if (strobe && write && !is_status) begin
            regs[reg_idx] <= wdata;
        end
    end

    // Pending bit is set by software and cleared by reading status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (strobe && is_status) begin
            if (write) begin
                if (wdata[0]) begin
                    pending <= 1'b1;
                end
            end else begin
                pending <= 1'b0;                    // Read clears
            end
        end
    end

    always_comb begin
        if (!sel) begin
            rdata = io_pkg::DATA_IDLE;              // Neutral for the AND merge
        end else if (is_status) begin
            rdata = {7'd0, pending};
        end else begin
            rdata = regs[reg_idx];
        end
    end

    assign irq = pending;

endmodule

// File: list.f
io_pkg.sv
io_decoder.sv
io_reg_device.sv
io_combiner.sv
io_devices.sv
tb_io_devices.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_io_devices -o sim_io
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_io 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

// File: tb_io_devices.sv
`timescale 1ns/10ps

module tb_io_devices;

    localparam logic [7:0] BASE_PORT      = 8'h40;
    localparam int         NUM_DEV        = 4;
    localparam int         TOTAL_REQS     = 48 + 42 + 16 + 4 + 400;
    localparam int         TIMEOUT_CYCLES = 4 * TOTAL_REQS + 200;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    logic [7:0] req_port;
    logic       req_write;
    logic [7:0] req_wdata;
    logic       resp_valid;
    logic       resp_ready;
    logic [7:0] resp_data;
    logic       interrupt;

    integer     seed;
    int         cycle;
    int         resp_cnt;
    int         accept_cyc;
    int         resp_cyc;
    logic       bp_on;                              // Random resp_ready when set
    logic       held;
    logic [7:0] held_data;
    logic [7:0] mregs [0:NUM_DEV-1][0:2];           // Model storage registers
    logic       mpend [0:NUM_DEV-1];                // Model pending bits
    logic [7:0] exp_q [$];                          // Expected responses in order

    io_devices i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_port   (req_port),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .interrupt  (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s = %0h, expected %0h",
                     $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Reference behavior of the port space, applied at acceptance
    function automatic void apply_model(input logic [7:0] p, input logic w, input logic [7:0] d);
        logic [7:0] off;
        logic [7:0] exp_byte;
        off      = p - BASE_PORT;
        exp_byte = 8'hFF;                           // Writes and unmapped ports
        if (off < 8'd16) begin
            if (off[1:0] == 2'd3) begin
                if (w) begin
                    if (d[0]) begin
                        mpend[off[3:2]] = 1'b1;
                    end
                end else begin
                    exp_byte = {7'd0, mpend[off[3:2]]};
                    mpend[off[3:2]] = 1'b0;         // Read clears
                end
            end else if (w) begin
                mregs[off[3:2]][off[1:0]] = d;
            end else begin
                exp_byte = mregs[off[3:2]][off[1:0]];
            end
        end
        exp_q.push_back(exp_byte);
    endfunction

    function automatic logic model_irq();
        logic any;
        any = 1'b0;
        for (int d = 0; d < NUM_DEV; d++) begin
            any = any | mpend[d];
        end
        return any;
    endfunction

    function automatic logic [7:0] unmapped_port();
        logic [7:0] p;
        p = 8'($random(seed));
        if (p >= BASE_PORT && p < BASE_PORT + 8'd16) begin
            p = p ^ 8'h80;                          // Move out of the windows
        end
        return p;
    endfunction

    task automatic step();
        logic [7:0] r8;
        @(posedge clk);
        if (bp_on) begin
            r8 = 8'($random(seed));
            resp_ready <= (r8 % 8'd10) >= 8'd3;     // Low about 30% of cycles
        end
    endtask

    task automatic send(input logic [7:0] p, input logic w, input logic [7:0] d);
        req_valid <= 1'b1;
        req_port  <= p;
        req_write <= w;
        req_wdata <= d;
        step();
        while (!req_ready) begin
            step();
        end
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        step();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    // Handshake monitor and response scoreboard
    always @(posedge clk) begin
        if (rst_n) begin
            check("req_ready", 32'(req_ready), 32'(!(resp_valid && !resp_ready)));
            if (held) begin
                check("resp_valid", 32'(resp_valid), 32'd1);
                check("resp_data", 32'(resp_data), 32'(held_data));
            end
            if (req_valid && req_ready) begin
                apply_model(req_port, req_write, req_wdata);
                accept_cyc = cycle;
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Response arrived at time %0t with no request outstanding", $time);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "extra response");
                end
                check("resp_data", 32'(resp_data), 32'(exp_q.pop_front()));
                resp_cnt++;
                resp_cyc = cycle;
            end
            held      = resp_valid && !resp_ready;
            held_data = resp_data;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int         n;
        logic [7:0] r8;
        seed       = 32'hf9b1fcba;
        resp_cnt   = 0;
        accept_cyc = 0;
        resp_cyc   = 0;
        bp_on      = 1'b0;
        held       = 1'b0;
        held_data  = 8'h00;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_port   = 8'h00;
        req_write  = 1'b0;
        req_wdata  = 8'h00;
        resp_ready = 1'b1;
        for (int d = 0; d < NUM_DEV; d++) begin
            mpend[d] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        step();

        // Write every storage register, then read all back
        repeat (2) begin
            for (int d = 0; d < NUM_DEV; d++)
                for (int r = 0; r < 3; r++)
                    send(BASE_PORT + 8'(4 * d + r), 1'b1, 8'($random(seed)));
            for (int d = 0; d < NUM_DEV; d++)
                for (int r = 0; r < 3; r++)
                    send(BASE_PORT + 8'(4 * d + r), 1'b0, 8'h00);
        end
        drain();

        // Unmapped accesses and mapped writes answer idle
        for (int i = 0; i < 20; i++) begin
            send(unmapped_port(), 1'(i % 2), 8'($random(seed)));
        end
        for (int i = 0; i < 10; i++) begin
            r8 = 8'($random(seed));
            send(BASE_PORT + (r8 & 8'h0F), 1'b1, 8'($random(seed)));
        end
        for (int d = 0; d < NUM_DEV; d++)
            for (int r = 0; r < 3; r++)
                send(BASE_PORT + 8'(4 * d + r), 1'b0, 8'h00);
        drain();

        // Status set and read-to-clear
        repeat (2) begin
            for (int d = 0; d < NUM_DEV; d++) begin
                send(BASE_PORT + 8'(4 * d + 3), 1'b1, 8'($random(seed)));
                drain();
                check("interrupt", 32'(interrupt), 32'(model_irq()));
            end
            for (int d = 0; d < NUM_DEV; d++) begin
                send(BASE_PORT + 8'(4 * d + 3), 1'b0, 8'h00);
                drain();
                check("interrupt", 32'(interrupt), 32'(model_irq()));
            end
        end

        // Isolated requests see a two cycle latency
        for (int k = 0; k < NUM_DEV; k++) begin
            n = resp_cnt;
            send(BASE_PORT + 8'(4 * k), 1'b0, 8'h00);
            while (resp_cnt == n) begin
                step();
            end
            check("latency", 32'(resp_cyc - accept_cyc), 32'd2);
        end
        drain();

        // Mixed traffic under back-pressure
        bp_on = 1'b1;
        for (int i = 0; i < 400; i++) begin
            r8 = 8'($random(seed));
            if (r8[7:6] == 2'd0) begin
                step();                             // Idle gap
            end
            case (r8[1:0])
                2'd0, 2'd1: send(BASE_PORT + 8'(r8[5:2]), 1'b0, 8'h00);
                2'd2:       send(BASE_PORT + 8'(r8[5:2]), 1'b1, 8'($random(seed)));
                default:    send(unmapped_port(), r8[2], 8'($random(seed)));
            endcase
        end
        drain();
        bp_on = 1'b0;
        resp_ready <= 1'b1;
        check("interrupt", 32'(interrupt), 32'(model_irq()));
        step();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
